// ==== source/pr_pkg.sv ====
// Shared definitions for the register board
// Data word, register address, R0 flag layout and KI source codes

package pr_pkg;

	// Bit 0 is the MSB, as on the W bus
	typedef logic [0:15] word_t;

	// 0 selects R0, 1..7 select R1..R7
	typedef logic [2:0] reg_addr_t;

	// R0 bits 0..8, order Z M V C L E G Y X
	typedef logic [0:8] flags_t;

	// Flag positions within flags_t and within R0
	localparam int FLAG_Z = 0; // Zero
	localparam int FLAG_M = 1; // Minus
	localparam int FLAG_V = 2; // Sticky overflow
	localparam int FLAG_C = 3; // Carry
	localparam int FLAG_L = 4; // Less
	localparam int FLAG_E = 5; // Equal
	localparam int FLAG_G = 6; // Greater
	localparam int FLAG_Y = 7; // Extension Y
	localparam int FLAG_X = 8; // Extension X

	// KI bus source, encoded as {kib, kia}
	typedef enum logic [1:0] {
		KI_RZ = 2'b00, // Interrupt request word
		KI_SR = 2'b01, // Status word
		KI_RB = 2'b10, // Binary load register
		KI_ZP = 2'b11  // Interrupt mask word
	} ki_sel_t;

endpackage

// ==== source/pr_ctrl.sv ====
// Register board control
// Strobe phase decode, R0 and user register write enables, L bus select
// Q protection of the R0 flags and the AWP load path

`timescale 1ns/1ps

module pr_ctrl #(
	parameter bit AWP_PRESENT = 1'b1
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              blr,      // Block register read, R0>>8 on L
	input  logic              lpc,      // LPC instruction
	input  logic              rpc,      // RPC instruction
	input  logic              wa,       // State WA
	input  pr_pkg::reg_addr_t addr,
	input  logic              as2,      // Selects strob2 phase for writes
	input  logic              w_r,      // Write to register
	input  logic              strob1,
	input  logic              strob2,
	input  logic              ustr0_fp, // Flag update from AWP
	input  logic              ust_leg,  // Compare result to L E G
	input  logic              q,        // System flag, user mode
	output logic              user_we,
	output logic              w_zmvc,
	output logic              w_legy,
	output logic              w8_x,
	output logic              lrp,
	output logic              cleg,
	output logic [1:0]        l_sel     // [1] R0>>8, [0] R1..R7, none R0
);

	logic strob1_q;  // Strobe levels one clock back
	logic strob2_q;
	logic strob1_p;  // First cycle of each strobe
	logic strob2_p;
	logic strob_a;
	logic strob_b;
	logic any_wr;
	logic sel_user;  // Address points at R1..R7
	logic r0_we;     // Direct R0 write
	logic lpc_ld;    // LPC loads whole R0
	logic awp_ld;

	// Previous strobe levels
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			strob1_q <= 1'b0;
			strob2_q <= 1'b0;
		end else begin
			strob1_q <= strob1;
			strob2_q <= strob2;
		end
	end

	// A strobe held high acts only once
	assign strob1_p = strob1 & ~strob1_q;
	assign strob2_p = strob2 & ~strob2_q;

	assign strob_a = strob1_p & ~as2; // Write phase without AS2
	assign strob_b = strob2_p & as2;  // Write phase with AS2
	assign any_wr  = (strob_a | strob_b) & w_r;

	assign sel_user = (addr != 3'd0);
	assign user_we  = any_wr & sel_user;
	assign r0_we    = any_wr & ~sel_user;

	assign lpc_ld = lpc & wa & strob_a;
	assign awp_ld = AWP_PRESENT & ustr0_fp & strob_a; // Only with AWP fitted

	// With Q set the user program cannot touch Z M V C and L E G Y
	assign w_zmvc = (r0_we & ~q) | lpc_ld | awp_ld;
	assign w_legy = (r0_we & ~q) | lpc_ld;
	assign w8_x   = r0_we | lpc_ld;  // X is always writable
	assign lrp    = r0_we | lpc_ld;  // Bits 9..15 likewise

	assign cleg = strob_b & ust_leg;

	// L bus source
	assign l_sel[1] = blr;
	assign l_sel[0] = ~blr & sel_user & ~(wa & rpc); // RPC in WA reads R0

endmodule

// ==== source/user_regs.sv ====
// User register file R1..R7
// One synchronous write port, one combinational read port

`timescale 1ns/1ps

module user_regs (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              we,
	input  pr_pkg::reg_addr_t addr,
	input  pr_pkg::word_t     w,
	output pr_pkg::word_t     rd
);

	import pr_pkg::*;

	word_t regs [1:7]; // No storage for address 0

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i <= 7; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (addr != 3'd0)) begin
			regs[addr] <= w;
		end
	end

	// Address 0 is R0 and reads as zero here
	assign rd = (addr == 3'd0) ? '0 : regs[addr];

endmodule

// ==== source/r0_flags.sv ====
// R0 status register
// CPU flags Z M V C L E G Y X in bits 0..8, user field in bits 9..15
// Direct loads from W, flag updates from ALU conditions, clears

`timescale 1ns/1ps

module r0_flags (
	input  logic          clk,
	input  logic          rst_n,
	input  pr_pkg::word_t w,
	input  logic          w_zmvc,  // Load Z M V C from W
	input  logic          w_legy,  // Load L E G Y from W
	input  logic          w8_x,    // Load X from W
	input  logic          lrp,     // Load bits 9..15 from W
	input  logic          cleg,    // Compare result to L E G
	input  logic          strob1,
	input  logic          ust_z,
	input  logic          ust_mc,
	input  logic          ust_v,
	input  logic          ust_y,
	input  logic          ust_x,
	input  logic          v_clr,   // Clear V
	input  logic          zs,      // ALU result zero
	input  logic          s0,      // ALU sign
	input  logic          s_1,     // ALU bit above sign
	input  logic          carry,
	input  logic          aryt,    // Arithmetic compare
	input  logic          exy,
	input  logic          exx,
	input  logic          zer,
	input  logic          clm,
	output pr_pkg::word_t r0
);

	import pr_pkg::*;

	flags_t      flags;
	logic [9:15] field; // Bits 9..15 as plain storage
	logic        cmp_l;
	logic        cmp_g;

	// Sign for arithmetic compare and carry for logical compare
	assign cmp_l = aryt ? s_1 : carry;
	assign cmp_g = aryt ? ~(s_1 | zs) : ~(carry | zs);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			flags <= '0;
			field <= '0;
		end else if (zer || clm) begin // Clear wins over any load
			flags <= '0;
			field <= '0;
		end else begin
			if (w_zmvc) begin
				flags[FLAG_Z:FLAG_C] <= w[FLAG_Z:FLAG_C];
			end else if (strob1) begin
				if (ust_z)
					flags[FLAG_Z] <= zs;
				if (ust_mc) begin
					flags[FLAG_M] <= s0;
					flags[FLAG_C] <= carry;
				end
				if (v_clr)
					flags[FLAG_V] <= 1'b0;
				else if (ust_v && (s0 != s_1)) // Overflow only sets V
					flags[FLAG_V] <= 1'b1;
			end
			if (w_legy) begin
				flags[FLAG_L:FLAG_Y] <= w[FLAG_L:FLAG_Y];
			end else begin
				if (cleg) begin
					flags[FLAG_L] <= cmp_l;
					flags[FLAG_E] <= zs;
					flags[FLAG_G] <= cmp_g;
				end
				if (strob1 && ust_y)
					flags[FLAG_Y] <= exy;
			end
			if (w8_x)
				flags[FLAG_X] <= w[FLAG_X];
			else if (strob1 && ust_x)
				flags[FLAG_X] <= exx;
			if (lrp)
				field <= w[9:15];
		end
	end

	assign r0 = {flags, field};

endmodule

// ==== source/sys_regs.sv ====
// System registers RB, NB, Q and BS
// System bus driver enables for NB, PN and Q

`timescale 1ns/1ps

module sys_regs #(
	parameter bit CPU_NUMBER = 1'b0
) (
	input  logic          clk,
	input  logic          rst_n,
	input  pr_pkg::word_t w,
	input  logic          w_bar,   // W to NB, Q, BS
	input  logic          strob1,
	input  logic          w_rba,   // W[10:15] to RB[10:15]
	input  logic          w_rbb,   // W[10:15] to RB[4:9]
	input  logic          w_rbc,   // W[12:15] to RB[0:3]
	input  logic          zer,
	input  logic          clm,
	input  logic          bar_nb,  // Put NB on the system bus
	input  logic          bp_nb,
	input  logic          pn_nb,
	input  logic          q_nb,
	input  logic          rpn,
	output pr_pkg::word_t rb,
	output logic [0:3]    nb,
	output logic          q,
	output logic          bs,
	output logic [0:3]    dnb,
	output logic          dpn,
	output logic          dqb,
	output logic          zgpn
);

	logic bar_ld;

	assign bar_ld = w_bar & strob1;

	// RB loads in three segments from the low bits of W
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rb <= '0;
		end else begin
			if (w_rbc)
				rb[0:3] <= w[12:15];
			if (w_rbb)
				rb[4:9] <= w[10:15];
			if (w_rba)
				rb[10:15] <= w[10:15];
		end
	end

	// Block number, system flag, block select
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			nb <= '0;
			q  <= 1'b0;
			bs <= 1'b0;
		end else begin
			if (zer)
				q <= 1'b0;
			else if (bar_ld)
				q <= w[10];
			if (clm) begin
				nb <= '0;
				bs <= 1'b0;
			end else if (bar_ld) begin
				nb <= w[12:15];
				bs <= w[11];
			end
		end
	end

	assign dnb  = nb & {4{bar_nb}};
	assign dqb  = q & q_nb;
	assign dpn  = ((bs ^ CPU_NUMBER) & bp_nb) | (CPU_NUMBER & pn_nb); // PN only on CPU 1
	assign zgpn = rpn ^ CPU_NUMBER;

endmodule

// ==== source/pr_bus_mux.sv ====
// Read paths of the register board
// L bus select and KI bus source select

`timescale 1ns/1ps

module pr_bus_mux (
	input  logic [1:0]    l_sel,   // [1] R0>>8, [0] R1..R7
	input  pr_pkg::word_t r0,
	input  pr_pkg::word_t user_rd,
	input  logic          kia,
	input  logic          kib,
	input  pr_pkg::word_t rz,
	input  pr_pkg::word_t zp,
	input  logic [0:9]    rs,
	input  logic          q,
	input  logic          bs,
	input  logic [0:3]    nb,
	input  pr_pkg::word_t rb,
	output pr_pkg::word_t l,
	output pr_pkg::word_t ki
);

	import pr_pkg::*;

	ki_sel_t ki_sel;

	always_comb begin
		if (l_sel[1])
			l = {8'd0, r0[0:7]}; // Upper byte moved down
		else if (l_sel[0])
			l = user_rd;
		else
			l = r0;
	end

	assign ki_sel = ki_sel_t'({kib, kia});

	always_comb begin
		case (ki_sel)
			KI_RZ:   ki = rz;
			KI_SR:   ki = {rs, q, bs, nb}; // Status word
			KI_RB:   ki = rb;
			default: ki = zp;
		endcase
	end

endmodule

// ==== source/pr_unit.sv ====
// Register board top level
// Control, user registers, R0, system registers and bus selection

`timescale 1ns/1ps

module pr_unit #(
	parameter bit CPU_NUMBER  = 1'b0,
	parameter bit AWP_PRESENT = 1'b1
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              blr,
	input  logic              lpc,
	input  logic              rpc,
	input  logic              wa,
	input  pr_pkg::reg_addr_t addr,
	input  logic              as2,
	input  logic              w_r,
	input  logic              strob1,
	input  logic              strob2,
	input  logic              ustr0_fp,
	input  logic              ust_leg,
	input  pr_pkg::word_t     w,
	input  logic              w_bar,
	input  logic              w_rba,
	input  logic              w_rbb,
	input  logic              w_rbc,
	input  logic              zer,
	input  logic              clm,
	input  logic              bar_nb,
	input  logic              bp_nb,
	input  logic              pn_nb,
	input  logic              q_nb,
	input  logic              rpn,
	input  logic              ust_z,
	input  logic              ust_mc,
	input  logic              ust_v,
	input  logic              ust_y,
	input  logic              ust_x,
	input  logic              v_clr,
	input  logic              zs,
	input  logic              s0,
	input  logic              s_1,
	input  logic              carry,
	input  logic              aryt,
	input  logic              exy,
	input  logic              exx,
	input  logic              kia,
	input  logic              kib,
	input  pr_pkg::word_t     rz,
	input  pr_pkg::word_t     zp,
	input  logic [0:9]        rs,
	output pr_pkg::word_t     l,
	output pr_pkg::word_t     ki,
	output pr_pkg::word_t     r0,
	output pr_pkg::word_t     rb,
	output logic [0:3]        nb,
	output logic              q,
	output logic              bs,
	output logic [0:3]        dnb,
	output logic              dpn,
	output logic              dqb,
	output logic              zgpn
);

	import pr_pkg::*;

	logic       user_we;
	logic       w_zmvc;
	logic       w_legy;
	logic       w8_x;
	logic       lrp;
	logic       cleg;
	logic [1:0] l_sel;
	word_t      user_rd; // R1..R7 read data

	pr_ctrl #(
		.AWP_PRESENT(AWP_PRESENT)
	) u_ctrl (
		.clk(clk), .rst_n(rst_n),
		.blr(blr), .lpc(lpc), .rpc(rpc), .wa(wa), .addr(addr),
		.as2(as2), .w_r(w_r), .strob1(strob1), .strob2(strob2),
		.ustr0_fp(ustr0_fp), .ust_leg(ust_leg), .q(q),
		.user_we(user_we), .w_zmvc(w_zmvc), .w_legy(w_legy),
		.w8_x(w8_x), .lrp(lrp), .cleg(cleg), .l_sel(l_sel)
	);

	user_regs u_user (
		.clk(clk), .rst_n(rst_n),
		.we(user_we), .addr(addr), .w(w), .rd(user_rd)
	);

	r0_flags u_r0 (
		.clk(clk), .rst_n(rst_n), .w(w),
		.w_zmvc(w_zmvc), .w_legy(w_legy), .w8_x(w8_x), .lrp(lrp), .cleg(cleg),
		.strob1(strob1), .ust_z(ust_z), .ust_mc(ust_mc), .ust_v(ust_v),
		.ust_y(ust_y), .ust_x(ust_x), .v_clr(v_clr),
		.zs(zs), .s0(s0), .s_1(s_1), .carry(carry), .aryt(aryt),
		.exy(exy), .exx(exx), .zer(zer), .clm(clm), .r0(r0)
	);

	sys_regs #(
		.CPU_NUMBER(CPU_NUMBER)
	) u_sys (
		.clk(clk), .rst_n(rst_n), .w(w), .w_bar(w_bar), .strob1(strob1),
		.w_rba(w_rba), .w_rbb(w_rbb), .w_rbc(w_rbc), .zer(zer), .clm(clm),
		.bar_nb(bar_nb), .bp_nb(bp_nb), .pn_nb(pn_nb), .q_nb(q_nb), .rpn(rpn),
		.rb(rb), .nb(nb), .q(q), .bs(bs),
		.dnb(dnb), .dpn(dpn), .dqb(dqb), .zgpn(zgpn)
	);

	pr_bus_mux u_mux (
		.l_sel(l_sel), .r0(r0), .user_rd(user_rd),
		.kia(kia), .kib(kib), .rz(rz), .zp(zp), .rs(rs),
		.q(q), .bs(bs), .nb(nb), .rb(rb),
		.l(l), .ki(ki)
	);

endmodule

// ==== verif/pr_unit_chk.sv ====
// Concurrent assertions for the register board, bound into pr_unit
// Q clear after zer, write enables only under a strobe, NB driver gating

`timescale 1ns/1ps

module pr_unit_chk (
	input logic       clk,
	input logic       rst_n,
	input logic       zer,
	input logic       q,
	input logic       strob1,
	input logic       strob2,
	input logic       user_we,
	input logic       w_zmvc,
	input logic       w_legy,
	input logic       w8_x,
	input logic       lrp,
	input logic       bar_nb,
	input logic [0:3] dnb
);

	int errors = 0; // Failed assertion count

	q_after_zer: assert property (@(posedge clk) disable iff (!rst_n) zer |=> !q)
		else begin
			errors++;
			$error("Q still set one cycle after zer");
		end

	// Every write enable comes from a strobe
	we_needs_strobe: assert property (@(posedge clk) disable iff (!rst_n)
			!(strob1 || strob2) |-> !(user_we || w_zmvc || w_legy || w8_x || lrp))
		else begin
			errors++;
			$error("Write enable high with no strobe");
		end

	dnb_gated: assert property (@(posedge clk) disable iff (!rst_n) !bar_nb |-> dnb == 4'd0)
		else begin
			errors++;
			$error("NB driven with bar_nb low");
		end

endmodule

bind pr_unit pr_unit_chk chk_i (
	.clk(clk), .rst_n(rst_n), .zer(zer), .q(q), .strob1(strob1), .strob2(strob2),
	.user_we(user_we), .w_zmvc(w_zmvc), .w_legy(w_legy), .w8_x(w8_x), .lrp(lrp),
	.bar_nb(bar_nb), .dnb(dnb)
);

// ==== verif/pr_unit_tb.sv ====
// Directed testbench for the register board
// Clock, reset, value check, model state and six test tasks

`timescale 1ns/1ps

module pr_unit_tb;

	import pr_pkg::*;

	logic       clk, rst_n, blr, lpc, rpc, wa, as2, w_r, strob1, strob2, ustr0_fp, ust_leg;
	logic       w_bar, w_rba, w_rbb, w_rbc, zer, clm, bar_nb, bp_nb, pn_nb, q_nb, rpn;
	logic       ust_z, ust_mc, ust_v, ust_y, ust_x, v_clr, zs, s0, s_1, carry, aryt, exy, exx;
	logic       kia, kib, q, bs, dpn, dqb, zgpn;
	reg_addr_t  addr;
	word_t      w, rz, zp, l, ki, r0, rb;
	logic [0:9] rs;
	logic [0:3] nb, dnb;

	// Expected register state
	word_t      r0_m, rb_m;
	logic [0:3] nb_m;
	logic       q_m, bs_m;
	int         seed;

	pr_unit #(.CPU_NUMBER(1'b0), .AWP_PRESENT(1'b1)) dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
			$display("test failed");
			$fatal(1, "value mismatch");
		end
	endtask

	function automatic void clear_pulses();
		{strob1, strob2, as2, w_r, w_bar, w_rba, w_rbb, w_rbc, zer, clm, lpc, wa} = '0;
		{ust_z, ust_mc, ust_v, ust_y, ust_x, v_clr, ust_leg, ustr0_fp} = '0;
	endfunction

	// Drop the pulse inputs and let outputs settle before the checks
	task automatic end_cycle();
		@(negedge clk);
		clear_pulses();
		#5;
	endtask

	task automatic wait_reset_state();
		int n;
		n = 0;
		while (r0 !== '0 || q !== 1'b0 || rb !== '0 || nb !== '0) begin
			@(negedge clk);
			n++;
			if (n > 4) begin
				$display("Registers did not reach their reset values within 4 cycles");
				$display("test failed");
				$fatal(1, "reset timeout");
			end
		end
	endtask

	task automatic write_reg(input reg_addr_t a, input word_t d);
		@(negedge clk);
		addr = a;
		w = d;
		w_r = 1'b1;
		strob1 = 1'b1; // Phase A with as2 low
		end_cycle();
	endtask

	task automatic load_bar(input word_t d);
		@(negedge clk);
		w = d;
		w_bar = 1'b1;
		strob1 = 1'b1;
		end_cycle();
		q_m = d[10];
		bs_m = d[11];
		nb_m = d[12:15];
	endtask

	// LPC in WA loads all of R0 whatever Q says
	task automatic load_r0_lpc(input word_t d);
		@(negedge clk);
		w = d;
		lpc = 1'b1;
		wa = 1'b1;
		strob1 = 1'b1;
		end_cycle();
		r0_m = d;
		check_value("r0 lpc", r0, r0_m);
	endtask

	task automatic clear_pulse(input bit use_clm);
		@(negedge clk);
		if (use_clm)
			clm = 1'b1;
		else
			zer = 1'b1;
		end_cycle();
		r0_m = '0;
		if (use_clm) begin
			nb_m = '0;
			bs_m = 1'b0;
		end else begin
			q_m = 1'b0;
		end
	endtask

	task automatic user_reg_readback();
		word_t user_m [1:7];
		for (int i = 1; i <= 7; i++) begin
			user_m[i] = word_t'($random(seed));
			write_reg(reg_addr_t'(i), user_m[i]);
		end
		for (int i = 1; i <= 7; i++) begin
			@(negedge clk);
			addr = reg_addr_t'(i);
			#5;
			check_value($sformatf("l R%0d", i), l, user_m[i]);
		end
	endtask

	task automatic r0_write_protect();
		word_t d;
		d = word_t'($random(seed));
		write_reg(3'd0, d);
		r0_m = d;
		check_value("r0", r0, r0_m);
		check_value("l", l, r0_m); // Address 0 reads R0
		load_bar(16'h0020);        // Q only
		d = word_t'($random(seed));
		write_reg(3'd0, d);
		r0_m[8:15] = d[8:15];      // Z..Y held by Q
		check_value("r0 with q", r0, r0_m);
		@(negedge clk);
		blr = 1'b1;
		#5;
		check_value("l blr", l, r0_m >> 8);
		@(negedge clk);
		blr = 1'b0;
	endtask

	task automatic alu_flag_update();
		flags_t     f;
		logic [7:0] r;
		clear_pulse(1'b0);
		f = '0;
		for (int n = 0; n < 32; n++) begin
			@(negedge clk);
			r = 8'($random(seed));
			{zs, s0, s_1, carry, aryt, exy, exx} = 7'($random(seed));
			{ust_z, ust_mc, ust_v, ust_y, ust_x} = r[4:0];
			v_clr = r[5] & r[6];
			ust_leg = r[7];
			strob1 = 1'b1;
			strob2 = 1'b1;
			as2 = 1'b1; // Compare result lands in phase B
			if (ust_z)
				f[FLAG_Z] = zs;
			if (ust_mc) begin
				f[FLAG_M] = s0;
				f[FLAG_C] = carry;
			end
			if (v_clr)
				f[FLAG_V] = 1'b0;
			else if (ust_v && s0 != s_1)
				f[FLAG_V] = 1'b1;
			if (ust_leg) begin
				f[FLAG_L] = aryt ? s_1 : carry;
				f[FLAG_E] = zs;
				f[FLAG_G] = aryt ? !(s_1 || zs) : !(carry || zs);
			end
			if (ust_y)
				f[FLAG_Y] = exy;
			if (ust_x)
				f[FLAG_X] = exx;
			end_cycle();
			check_value("r0 flags", r0[0:8], f);
		end
		r0_m[0:8] = f;
	endtask

	task automatic sys_reg_drivers();
		word_t d;
		for (int p = 0; p < 4; p++) begin
			d = word_t'($random(seed));
			d[10:11] = 2'(p); // Every Q and BS pair
			load_bar(d);
			check_value("nb", nb, nb_m);
			check_value("q", q, q_m);
			check_value("bs", bs, bs_m);
			for (int c = 0; c < 32; c++) begin
				@(negedge clk);
				{bar_nb, bp_nb, pn_nb, q_nb, rpn} = 5'(c);
				#5;
				check_value("dnb", dnb, bar_nb ? nb_m : 4'h0);
				check_value("dqb", dqb, q_m & q_nb);
				check_value("dpn", dpn, bs_m & bp_nb); // pn_nb ignored on CPU 0
				check_value("zgpn", zgpn, rpn);
			end
		end
		@(negedge clk);
		{bar_nb, bp_nb, pn_nb, q_nb, rpn} = '0;
		for (int s = 0; s < 3; s++) begin
			d = word_t'($random(seed));
			@(negedge clk);
			w = d;
			{w_rbc, w_rbb, w_rba} = 3'b100 >> s;
			case (s)
				0:       rb_m[0:3] = d[12:15];
				1:       rb_m[4:9] = d[10:15];
				default: rb_m[10:15] = d[10:15];
			endcase
			end_cycle();
			check_value("rb", rb, rb_m);
		end
	endtask

	task automatic ki_source_select();
		word_t exp;
		for (int n = 0; n < 4; n++) begin
			for (int c = 0; c < 4; c++) begin
				@(negedge clk);
				rz = word_t'($random(seed));
				zp = word_t'($random(seed));
				rs = 10'($random(seed));
				{kib, kia} = 2'(c);
				#5;
				if (!kia && !kib)
					exp = rz;
				else if (kia && !kib)
					exp = {rs, q_m, bs_m, nb_m}; // Status word
				else if (!kia && kib)
					exp = rb_m;
				else
					exp = zp;
				check_value("ki", ki, exp);
			end
		end
	endtask

	task automatic register_clears();
		load_r0_lpc(word_t'($random(seed)) | 16'h8001);
		load_bar(16'h003a); // Q, BS, NB 1010
		clear_pulse(1'b0);
		check_value("r0 after zer", r0, r0_m);
		check_value("q after zer", q, q_m);
		check_value("nb after zer", nb, nb_m);
		check_value("bs after zer", bs, bs_m);
		load_r0_lpc(word_t'($random(seed)) | 16'h8001);
		load_bar(16'h003a);
		clear_pulse(1'b1);
		check_value("r0 after clm", r0, r0_m);
		check_value("nb after clm", nb, nb_m);
		check_value("bs after clm", bs, bs_m);
		check_value("q after clm", q, q_m); // Q survives clm
	endtask

	initial begin
		seed = 32'h0c47_24d2;
		rst_n = 1'b0;
		clear_pulses();
		{blr, rpc, addr, kia, kib, bar_nb, bp_nb, pn_nb, q_nb, rpn} = '0;
		{zs, s0, s_1, carry, aryt, exy, exx} = '0;
		{w, rz, zp, rs} = '0;
		{r0_m, rb_m, nb_m, q_m, bs_m} = '0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		wait_reset_state();
		user_reg_readback();
		r0_write_protect();
		alu_flag_update();
		sys_reg_drivers();
		ki_source_select();
		register_clears();
		@(negedge clk);
		if (dut_i.chk_i.errors == 0) begin
			$display("test passed");
			$finish;
		end else begin
			$display("Assertion failures: %0d", dut_i.chk_i.errors);
			$display("test failed");
			$fatal(1, "assertion errors");
		end
	end

endmodule

// ==== pr_unit.f ====
source/pr_pkg.sv
source/pr_ctrl.sv
source/user_regs.sv
source/r0_flags.sv
source/sys_regs.sv
source/pr_bus_mux.sv
source/pr_unit.sv
verif/pr_unit_chk.sv
verif/pr_unit_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= pr_unit_tb
FILELIST  ?= pr_unit.f
PASS_MSG  := test passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
